// File: alu/alu.sv
// Combinational RV32IM ALU
// Base integer operations plus multiply, divide and remainder
// Divide by zero and signed overflow follow the RISC-V rules
// Zero flag on the result
module alu
    import ex_pkg::*;
#(
    parameter int NB_DATA = 32
) (
    input  logic [NB_DATA-1:0] i_data1,
    input  logic [NB_DATA-1:0] i_data2,
    input  alu_op_e            i_alu_op,
    output logic [NB_DATA-1:0] o_result,
    output logic               o_zero
);

    localparam int NB_SHAMT = $clog2(NB_DATA);
    localparam logic [NB_DATA-1:0] MIN_NEG = {1'b1, {(NB_DATA-1){1'b0}}};

    logic [NB_SHAMT-1:0] shamt;
    logic                lt_s;
    logic                lt_u;

    // Full width products for the MULH variants
    logic signed [2*NB_DATA-1:0] prod_ss;
    logic signed [2*NB_DATA-1:0] prod_su;
    logic        [2*NB_DATA-1:0] prod_uu;

    logic                      div_by_zero;
    logic                      div_ovf;
    logic signed [NB_DATA-1:0] divisor_s;
    logic        [NB_DATA-1:0] divisor_u;
    logic signed [NB_DATA-1:0] quot_s;
    logic signed [NB_DATA-1:0] rem_s;
    logic        [NB_DATA-1:0] quot_u;
    logic        [NB_DATA-1:0] rem_u;

    assign shamt = i_data2[NB_SHAMT-1:0];  // Upper bits ignored
    assign lt_s  = $signed(i_data1) < $signed(i_data2);
    assign lt_u  = i_data1 < i_data2;

    assign prod_ss = $signed(i_data1) * $signed(i_data2);
    assign prod_su = $signed({{NB_DATA{i_data1[NB_DATA-1]}}, i_data1}) *
                     $signed({{NB_DATA{1'b0}}, i_data2});
    assign prod_uu = {{NB_DATA{1'b0}}, i_data1} * {{NB_DATA{1'b0}}, i_data2};

    assign div_by_zero = (i_data2 == '0);
    assign div_ovf     = (i_data1 == MIN_NEG) && (i_data2 == '1);

    // Divide by one on overflow so quotient is the dividend and remainder zero
    assign divisor_s = (div_by_zero || div_ovf) ? NB_DATA'(1) : i_data2;
    assign divisor_u = div_by_zero ? NB_DATA'(1) : i_data2;

    assign quot_s = $signed(i_data1) / divisor_s;
    assign rem_s  = $signed(i_data1) % divisor_s;
    assign quot_u = i_data1 / divisor_u;
    assign rem_u  = i_data1 % divisor_u;

    always_comb begin
        case (i_alu_op)
            ALU_ADD:    o_result = i_data1 + i_data2;
            ALU_SUB:    o_result = i_data1 - i_data2;
            ALU_SLL:    o_result = i_data1 << shamt;
            ALU_SLT:    o_result = {{(NB_DATA-1){1'b0}}, lt_s};
            ALU_SLTU:   o_result = {{(NB_DATA-1){1'b0}}, lt_u};
            ALU_XOR:    o_result = i_data1 ^ i_data2;
            ALU_SRL:    o_result = i_data1 >> shamt;
            ALU_SRA:    o_result = $signed(i_data1) >>> shamt;
            ALU_OR:     o_result = i_data1 | i_data2;
            ALU_AND:    o_result = i_data1 & i_data2;
            ALU_MUL:    o_result = prod_uu[NB_DATA-1:0];  // Low half same for all signs
            ALU_MULH:   o_result = prod_ss[2*NB_DATA-1:NB_DATA];
            ALU_MULHSU: o_result = prod_su[2*NB_DATA-1:NB_DATA];
            ALU_MULHU:  o_result = prod_uu[2*NB_DATA-1:NB_DATA];
            ALU_DIV:    o_result = div_by_zero ? '1 : quot_s;
            ALU_DIVU:   o_result = div_by_zero ? '1 : quot_u;
            ALU_REM:    o_result = div_by_zero ? i_data1 : rem_s;
            ALU_REMU:   o_result = div_by_zero ? i_data1 : rem_u;
            default:    o_result = '0;
        endcase
    end

    assign o_zero = (o_result == '0);

endmodule

// File: common/ex_pkg.sv
// Shared definitions for the RV32IM execute stage
// ALU operation encoding, opcode and funct constants
// Instruction word union with R-type and I-type views
// Control and registered output bundles
package ex_pkg;

    // Data width of the stage output bundle
    localparam int XLEN = 32;

    // ALU operation codes
    typedef enum logic [4:0] {
        ALU_ADD    = 5'b00000,
        ALU_SUB    = 5'b00001,
        ALU_SLL    = 5'b00010,
        ALU_SLT    = 5'b00011,
        ALU_SLTU   = 5'b00100,
        ALU_XOR    = 5'b00101,
        ALU_SRL    = 5'b00110,
        ALU_SRA    = 5'b00111,
        ALU_OR     = 5'b01000,
        ALU_AND    = 5'b01001,
        ALU_MUL    = 5'b01010,
        ALU_MULH   = 5'b01011,
        ALU_MULHSU = 5'b01100,
        ALU_MULHU  = 5'b01101,
        ALU_DIV    = 5'b01110,
        ALU_DIVU   = 5'b01111,
        ALU_REM    = 5'b10000,
        ALU_REMU   = 5'b10001
    } alu_op_e;

    // Major opcodes handled here
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // funct7 values
    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;  // SUB, SRA
    localparam logic [6:0] F7_MULDIV = 7'b0000001;  // M extension

    // Branch conditions in funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Same 32 bits seen as R-type or as I-type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
    } instr_u;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;    // I immediate replaces rs2
        logic    is_branch;
        logic    legal;      // Supported opcode and funct
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] result;
        logic            zero;
        logic            branch_taken;
        logic [XLEN-1:0] target;
        logic            illegal;
    } ex_out_t;

endpackage

// File: hdl/alu_control.sv
// Instruction decoder for the execute stage
// Maps opcode, funct3 and funct7 onto the ALU operation,
// the operand select, the branch enable and the legal flag
module alu_control
    import ex_pkg::*;
(
    input  instr_u i_instr,
    output ctrl_t  o_ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = i_instr.r_fmt.opcode;
    assign funct3 = i_instr.r_fmt.funct3;
    assign funct7 = i_instr.r_fmt.funct7;

    always_comb begin
        o_ctrl.alu_op    = ALU_ADD;
        o_ctrl.use_imm   = 1'b0;
        o_ctrl.is_branch = 1'b0;
        o_ctrl.legal     = 1'b0;

        case (opcode)
            OPC_OP: begin
                o_ctrl.legal = (funct7 == F7_BASE) || (funct7 == F7_MULDIV) ||
                               ((funct7 == F7_ALT) && ((funct3 == 3'd0) || (funct3 == 3'd5)));
                if (funct7[0]) begin
                    // funct3 order matches the M block of the enumeration
                    o_ctrl.alu_op = alu_op_e'(ALU_MUL + funct3);
                end else begin
                    case (funct3)
                        3'd0: o_ctrl.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                        3'd1: o_ctrl.alu_op = ALU_SLL;
                        3'd2: o_ctrl.alu_op = ALU_SLT;
                        3'd3: o_ctrl.alu_op = ALU_SLTU;
                        3'd4: o_ctrl.alu_op = ALU_XOR;
                        3'd5: o_ctrl.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                        3'd6: o_ctrl.alu_op = ALU_OR;
                        default: o_ctrl.alu_op = ALU_AND;
                    endcase
                end
            end

            OPC_OP_IMM: begin
                o_ctrl.use_imm = 1'b1;
                o_ctrl.legal   = 1'b1;
                case (funct3)
                    3'd0: o_ctrl.alu_op = ALU_ADD;
                    3'd1: begin
                        o_ctrl.alu_op = ALU_SLL;
                        o_ctrl.legal  = (funct7 == F7_BASE);  // Upper imm bits fixed
                    end
                    3'd2: o_ctrl.alu_op = ALU_SLT;
                    3'd3: o_ctrl.alu_op = ALU_SLTU;
                    3'd4: o_ctrl.alu_op = ALU_XOR;
                    3'd5: begin
                        o_ctrl.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                        o_ctrl.legal  = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                    end
                    3'd6: o_ctrl.alu_op = ALU_OR;
                    default: o_ctrl.alu_op = ALU_AND;
                endcase
            end

            OPC_BRANCH: begin
                // funct3 2 and 3 are not branch conditions
                o_ctrl.legal     = (funct3 != 3'd2) && (funct3 != 3'd3);
                o_ctrl.is_branch = o_ctrl.legal;
                o_ctrl.alu_op    = ALU_ADD;
            end

            default: begin
                o_ctrl.legal = 1'b0;  // Opcode not executed here
            end
        endcase
    end

endmodule

// File: hdl/branch_compare.sv
// Conditional branch evaluation
// BEQ, BNE, BLT, BGE, BLTU and BGEU selected by funct3
// Branch target as pc plus the B immediate
module branch_compare
    import ex_pkg::*;
#(
    parameter int NB_DATA = 32
) (
    input  logic [NB_DATA-1:0] i_rs1,
    input  logic [NB_DATA-1:0] i_rs2,
    input  logic [2:0]         i_funct3,
    input  logic               i_is_branch,
    input  logic [NB_DATA-1:0] i_pc,
    input  logic [NB_DATA-1:0] i_imm_b,
    output logic               o_taken,
    output logic [NB_DATA-1:0] o_target
);

    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond;

    assign eq   = (i_rs1 == i_rs2);
    assign lt_s = $signed(i_rs1) < $signed(i_rs2);
    assign lt_u = i_rs1 < i_rs2;

    always_comb begin
        case (i_funct3)
            F3_BEQ:  cond = eq;
            F3_BNE:  cond = !eq;
            F3_BLT:  cond = lt_s;
            F3_BGE:  cond = !lt_s;
            F3_BLTU: cond = lt_u;
            F3_BGEU: cond = !lt_u;
            default: cond = 1'b0;  // Not a branch condition
        endcase
    end

    assign o_taken  = i_is_branch && cond;
    assign o_target = i_pc + i_imm_b;

endmodule

// File: hdl/ex_stage.sv
// Execute stage top level
// Decoder, operand mux, ALU and branch comparator
// One output register stage, fixed latency of one cycle
module ex_stage
    import ex_pkg::*;
#(
    parameter int NB_DATA = XLEN
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_valid,
    input  instr_u             i_instr,
    input  logic [NB_DATA-1:0] i_rs1,
    input  logic [NB_DATA-1:0] i_rs2,
    input  logic [NB_DATA-1:0] i_pc,
    output logic               o_valid,
    output ex_out_t            o_ex
);

    ctrl_t              ctrl;
    logic [NB_DATA-1:0] op2;
    logic [NB_DATA-1:0] imm_b;
    logic [NB_DATA-1:0] alu_result;
    logic               alu_zero;
    logic               taken;
    logic [NB_DATA-1:0] target;
    ex_out_t            ex_next;

    alu_control u_alu_control (
        .i_instr (i_instr),
        .o_ctrl  (ctrl)
    );

    operand_select #(.NB_DATA(NB_DATA)) u_operand_select (
        .i_instr (i_instr),
        .i_ctrl  (ctrl),
        .i_rs2   (i_rs2),
        .o_op2   (op2),
        .o_imm_b (imm_b)
    );

    alu #(.NB_DATA(NB_DATA)) u_alu (
        .i_data1  (i_rs1),
        .i_data2  (op2),
        .i_alu_op (ctrl.alu_op),
        .o_result (alu_result),
        .o_zero   (alu_zero)
    );

    branch_compare #(.NB_DATA(NB_DATA)) u_branch_compare (
        .i_rs1       (i_rs1),
        .i_rs2       (i_rs2),
        .i_funct3    (i_instr.r_fmt.funct3),
        .i_is_branch (ctrl.is_branch),
        .i_pc        (i_pc),
        .i_imm_b     (imm_b),
        .o_taken     (taken),
        .o_target    (target)
    );

    // Illegal instructions pass through with a zero result
    always_comb begin
        ex_next.result       = ctrl.legal ? alu_result : '0;
        ex_next.zero         = ctrl.legal ? alu_zero : 1'b1;
        ex_next.branch_taken = taken;   // Already low unless a legal branch
        ex_next.target       = target;
        ex_next.illegal      = !ctrl.legal;
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
        if (i_valid) begin
            o_ex <= ex_next;            // Holds while no valid input
        end
    end

endmodule

// File: hdl/operand_select.sv
// Immediate extraction and second operand mux
// Sign-extended I immediate replaces rs2 for OP-IMM
// B immediate gathered from the R-type fields for branches
module operand_select
    import ex_pkg::*;
#(
    parameter int NB_DATA = 32
) (
    input  instr_u             i_instr,
    input  ctrl_t              i_ctrl,
    input  logic [NB_DATA-1:0] i_rs2,
    output logic [NB_DATA-1:0] o_op2,
    output logic [NB_DATA-1:0] o_imm_b
);

    logic [11:0]        imm_i_raw;
    logic [12:0]        imm_b_raw;
    logic [NB_DATA-1:0] imm_i;

    assign imm_i_raw = i_instr.i_fmt.imm;

    // B layout: imm[12|10:5] in funct7, imm[4:1|11] in rd
    assign imm_b_raw = {
        i_instr.r_fmt.funct7[6],
        i_instr.r_fmt.rd[0],
        i_instr.r_fmt.funct7[5:0],
        i_instr.r_fmt.rd[4:1],
        1'b0
    };

    assign imm_i   = {{(NB_DATA-12){imm_i_raw[11]}}, imm_i_raw};
    assign o_imm_b = {{(NB_DATA-13){imm_b_raw[12]}}, imm_b_raw};

    // Shift immediates carry funct7 above shamt, ALU only reads shamt
    assign o_op2 = i_ctrl.use_imm ? imm_i : i_rs2;

endmodule

// File: tb.f
common/ex_pkg.sv
hdl/alu_control.sv
alu/alu.sv
hdl/operand_select.sv
hdl/branch_compare.sv
hdl/ex_stage.sv
verif/ex_stage_props.sv
verif/clk_gen.sv
verif/tb_ex_stage.sv

// File: verif/clk_gen.sv
// Testbench clock and synchronous reset source
// Reset held for a fixed number of rising edges
module clk_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 10
) (
    output logic o_clk,
    output logic o_rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    initial begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);
        #2 o_rst = 1'b0;  // Released just after the edge like other inputs
    end

endmodule

// File: verif/ex_stage_props.sv
// Bound checker for the execute stage
// Reference model of result, flags, branch decision and target
// Concurrent assertions with a shared failure counter
module ex_stage_props
    import ex_pkg::*;
#(
    parameter int NB_DATA = 32
) (
    input logic               i_clk,
    input logic               i_rst,
    input logic               i_valid,
    input instr_u             i_instr,
    input logic [NB_DATA-1:0] i_rs1,
    input logic [NB_DATA-1:0] i_rs2,
    input logic [NB_DATA-1:0] i_pc,
    input logic               o_valid,
    input ex_out_t            o_ex
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NB_SH = $clog2(NB_DATA);

    int                 err_count = 0;  // Read by the testbench
    logic [NB_DATA-1:0] exp_result;
    logic               exp_legal;
    logic               exp_taken;
    logic [NB_DATA-1:0] exp_target;

    function automatic logic is_legal(instr_u ins);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = ins.r_fmt.funct7;
        f3 = ins.r_fmt.funct3;
        case (ins.r_fmt.opcode)
            OPC_OP:     return f7 inside {7'h00, 7'h01} || (f7 == 7'h20 && f3 inside {0, 5});
            OPC_OP_IMM: return (f3 == 3'd1) ? f7 == 7'h00 :
                               (f3 == 3'd5) ? f7 inside {7'h00, 7'h20} : 1'b1;
            OPC_BRANCH: return f3[2:1] != 2'b01;
            default:    return 1'b0;
        endcase
    endfunction

    // RV32IM result of a legal OP, OP-IMM or BRANCH word
    function automatic logic [NB_DATA-1:0] calc_result(instr_u ins, logic [NB_DATA-1:0] a,
                                                     logic [NB_DATA-1:0] rs2);
        logic [NB_DATA-1:0]   b;
        logic [NB_DATA-1:0]   sra;
        logic [NB_DATA-1:0]   abs_a;
        logic [NB_DATA-1:0]   abs_b;
        logic [NB_DATA-1:0]   quo_s;
        logic [NB_DATA-1:0]   rem_s;
        logic [2*NB_DATA-1:0] prod;
        logic [2:0]           f3;
        f3    = ins.r_fmt.funct3;
        b     = (ins.r_fmt.opcode == OPC_OP_IMM) ?
                {{(NB_DATA-12){ins.i_fmt.imm[11]}}, ins.i_fmt.imm} : rs2;
        sra   = $signed(a) >>> b[NB_SH-1:0];
        // Sign extension picks MULH, MULHSU or MULHU
        prod  = {{NB_DATA{a[NB_DATA-1] && (f3 == 3'd1 || f3 == 3'd2)}}, a} *
                {{NB_DATA{b[NB_DATA-1] && (f3 == 3'd1)}}, b};
        abs_a = a[NB_DATA-1] ? -a : a;
        abs_b = b[NB_DATA-1] ? -b : b;
        quo_s = (a[NB_DATA-1] ^ b[NB_DATA-1]) ? -(abs_a / abs_b) : abs_a / abs_b;
        rem_s = a[NB_DATA-1] ? -(abs_a % abs_b) : abs_a % abs_b;  // Sign of dividend
        if (ins.r_fmt.opcode == OPC_BRANCH)
            return a + b;  // Branches keep the ALU on ADD of rs1 and rs2
        if (ins.r_fmt.opcode == OPC_OP && ins.r_fmt.funct7 == 7'h01) begin
            case (f3)
                3'd0:    return prod[NB_DATA-1:0];
                3'd4:    return (b == '0) ? '1 : quo_s;
                3'd5:    return (b == '0) ? '1 : a / b;
                3'd6:    return (b == '0) ? a : rem_s;
                3'd7:    return (b == '0) ? a : a % b;
                default: return prod[2*NB_DATA-1:NB_DATA];
            endcase
        end
        case (f3)
            3'd0:    return (ins.r_fmt.opcode == OPC_OP && ins.r_fmt.funct7[5]) ? a - b : a + b;
            3'd1:    return a << b[NB_SH-1:0];
            3'd2:    return NB_DATA'($signed(a) < $signed(b));
            3'd3:    return NB_DATA'(a < b);
            3'd4:    return a ^ b;
            3'd5:    return ins.r_fmt.funct7[5] ? sra : a >> b[NB_SH-1:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic calc_taken(instr_u ins, logic [NB_DATA-1:0] a,
                                        logic [NB_DATA-1:0] b);
        if (ins.r_fmt.opcode != OPC_BRANCH)
            return 1'b0;
        case (ins.r_fmt.funct3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            3'd7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    always_ff @(posedge i_clk) begin
        exp_legal  <= is_legal(i_instr);
        exp_result <= is_legal(i_instr) ? calc_result(i_instr, i_rs1, i_rs2) : '0;
        exp_taken  <= calc_taken(i_instr, i_rs1, i_rs2);
        // B offset in word bits 31, 7, 30:25 and 11:8
        exp_target <= i_pc + {{(NB_DATA-12){i_instr[31]}}, i_instr[7], i_instr[30:25],
                              i_instr[11:8], 1'b0};
    end

    a_valid_timing: assert property (@(posedge i_clk)
        1'b1 |=> o_valid == (!$past(i_rst) && $past(i_valid)))
        else begin
            err_count++;
            $error("%0t: o_valid does not follow i_valid by one cycle", $time);
        end

    // Output bundle keeps its value over cycles without a valid input
    a_hold: assert property (@(posedge i_clk) !i_valid |=> o_ex === $past(o_ex))
        else begin
            err_count++;
            $error("%0t: o_ex changed without a valid input", $time);
        end

    a_result: assert property (@(posedge i_clk) o_valid |-> o_ex.result == exp_result)
        else begin
            err_count++;
            $error("%0t: result %h, expected %h", $time, $sampled(o_ex.result),
                   $sampled(exp_result));
        end

    a_flags: assert property (@(posedge i_clk) o_valid |->
        (o_ex.illegal == !exp_legal) && (o_ex.zero == (exp_result == '0)))
        else begin
            err_count++;
            $error("%0t: zero or illegal flag wrong for result %h", $time, $sampled(exp_result));
        end

    a_branch: assert property (@(posedge i_clk) o_valid |->
        (o_ex.branch_taken == exp_taken) && (o_ex.target == exp_target))
        else begin
            err_count++;
            $error("%0t: taken %b target %h, expected %b %h", $time,
                   $sampled(o_ex.branch_taken), $sampled(o_ex.target),
                   $sampled(exp_taken), $sampled(exp_target));
        end

endmodule

// File: verif/tb_ex_stage.sv
// Testbench for the execute stage
// LFSR stimulus for six instruction groups, checked by bound assertions
// Per-test failure counts, run limit and final verdict
module tb_ex_stage
    import ex_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NB_DATA    = 32;
    localparam int RST_CYCLES = 10;
    localparam int N_TESTS    = 6;
    localparam int N_ITEMS    = 64;  // Instructions per test
    localparam int N_DRAIN    = 2;   // Idle cycles so the last check fires
    localparam int MAX_CYCLES = RST_CYCLES + N_TESTS * (N_ITEMS + N_DRAIN) + 50;

    logic               clk;
    logic               rst;
    logic               valid;
    instr_u             instr;
    logic [NB_DATA-1:0] rs1;
    logic [NB_DATA-1:0] rs2;
    logic [NB_DATA-1:0] pc;
    logic               out_valid;
    ex_out_t            out_ex;
    logic [31:0]        lfsr_state = 32'he0146ed4;
    int                 cycles = 0;
    int                 total_errs = 0;
    int                 failed_tests = 0;
    int                 errs_before;
    int                 errs;
    string              test_names [N_TESTS] = '{"valid_timing", "op_reg", "op_imm",
                                                 "m_ext", "branch", "illegal"};

    bind ex_stage ex_stage_props #(.NB_DATA(NB_DATA)) u_props (
        .i_clk(i_clk), .i_rst(i_rst), .i_valid(i_valid), .i_instr(i_instr),
        .i_rs1(i_rs1), .i_rs2(i_rs2), .i_pc(i_pc), .o_valid(o_valid), .o_ex(o_ex)
    );

    clk_gen #(.PERIOD_NS(40), .RST_CYCLES(RST_CYCLES)) u_clk_gen (.o_clk(clk), .o_rst(rst));

    ex_stage #(.NB_DATA(NB_DATA)) dut0 (
        .i_clk(clk), .i_rst(rst), .i_valid(valid), .i_instr(instr),
        .i_rs1(rs1), .i_rs2(rs2), .i_pc(pc), .o_valid(out_valid), .o_ex(out_ex)
    );

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] val;
        logic        fb;
        int          k;
        val = '0;
        for (k = 0; k < nbits; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val        = {val[30:0], fb};
        end
        return val;
    endfunction

    task automatic issue(input logic vld, input instr_u ins, input logic [31:0] a,
                         input logic [31:0] b);
        @(posedge clk);
        #2;
        valid = vld;
        instr = ins;
        rs1   = a;
        rs2   = b;
        pc    = rand_bits(30) << 2;
    endtask

    task automatic drive_item(input int test_id);
        logic [6:0]  f7;
        logic [4:0]  f5;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [6:0]  opc;
        logic [31:0] a;
        logic [31:0] b;
        logic        vld;
        vld = 1'b1;
        opc = OPC_OP;
        f7  = F7_BASE;
        f5  = 5'd2;
        rd  = 5'd3;
        f3  = 3'(rand_bits(3));
        a   = rand_bits(32);
        b   = (rand_bits(2) == 0) ? a : rand_bits(32);  // Equal operands now and then
        case (test_id)
            0: begin
                vld = 1'(rand_bits(1));  // Gaps in the strobe
                f3  = 3'd0;
            end
            1: f7 = (f3 inside {3'd0, 3'd5} && rand_bits(1)) ? F7_ALT : F7_BASE;
            2: begin
                opc = OPC_OP_IMM;
                f5  = 5'(rand_bits(5));
                f7  = (f3 == 3'd1) ? F7_BASE :
                      (f3 == 3'd5) ? (rand_bits(1) ? F7_ALT : F7_BASE) : 7'(rand_bits(7));
            end
            3: begin
                f7 = F7_MULDIV;
                case (rand_bits(3))
                    0: b = '0;
                    1: begin
                        a = 32'h8000_0000;  // Signed overflow pair
                        b = '1;
                    end
                    default: ;
                endcase
            end
            4: begin
                opc = OPC_BRANCH;
                f7  = 7'(rand_bits(7));
                rd  = 5'(rand_bits(5));
                f3  = (f3[2:1] == 2'b01) ? f3 + 3'd4 : f3;  // Skip funct3 2 and 3
            end
            default: begin
                case (rand_bits(2))
                    0: f7 = 7'(rand_bits(7)) | 7'h40;
                    1: begin
                        opc = OPC_OP_IMM;
                        f3  = 3'd1;
                        f7  = 7'(rand_bits(7)) | 7'h40;
                    end
                    2: begin
                        opc = OPC_BRANCH;
                        f3  = {2'b01, f3[0]};
                    end
                    default: opc = 7'b0110111;  // LUI not executed here
                endcase
            end
        endcase
        issue(vld, {f7, f5, 5'd1, f3, rd, opc}, a, b);
    endtask

    initial begin
        valid = 1'b0;
        instr = '0;
        rs1   = '0;
        rs2   = '0;
        pc    = '0;
        wait (rst == 1'b0);
        for (int t = 0; t < N_TESTS; t++) begin
            errs_before = dut0.u_props.err_count;
            repeat (N_ITEMS) drive_item(t);
            repeat (N_DRAIN) issue(1'b0, '0, '0, '0);
            errs = dut0.u_props.err_count - errs_before;
            if (errs != 0)
                failed_tests++;
            $display("Test %0d %s: %s, %0d assertion failures", t, test_names[t],
                     (errs == 0) ? "ok" : "bad", errs);
        end
        total_errs = dut0.u_props.err_count;  // Includes failures during reset
        $display("Tests run: %0d, tests failed: %0d, assertion failures: %0d",
                 N_TESTS, failed_tests, total_errs);
        if (total_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Run limit from the test lengths plus reset and a margin
    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
